/* hdl/sa_pkg.sv */
package sa_pkg;

    // ----------------------------------------
    // array and memory sizes
    // ----------------------------------------
    localparam int NUM_ROW      = 4;
    localparam int NUM_COL      = 4;
    localparam int DATA_W       = 8;                      // operand width
    localparam int ACC_W        = 32;                     // accumulator width, wraps
    localparam int ADDR_W       = 6;
    localparam int BANK_DEPTH   = 1 << ADDR_W;
    localparam int ROW_IDX_W    = $clog2(NUM_ROW);

    // last read issue to last product landed
    localparam int SKEW_MAX     = NUM_ROW - 1;
    localparam int DRAIN_CYCLES = SKEW_MAX + 1 + NUM_ROW + NUM_COL - 1 + 2;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [DATA_W-1:0]    operand_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [ROW_IDX_W-1:0] row_idx_t;

    typedef operand_t [NUM_ROW-1:0] row_vec_t;            // left lanes
    typedef operand_t [NUM_COL-1:0] col_vec_t;            // top lanes
    typedef acc_t     [NUM_COL-1:0] result_row_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic     en;
        addr_t    addr;
        row_vec_t data;
    } host_left_wr_t;

    typedef struct packed {
        logic     en;
        addr_t    addr;
        col_vec_t data;
    } host_top_wr_t;

    typedef struct packed {
        logic  rd_en;
        logic  valid;
        addr_t addr;
    } stream_cmd_t;

    typedef struct packed {
        logic     en;
        row_idx_t row;
    } wb_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_STREAM,
        ST_DRAIN,
        ST_WRITEBACK,
        ST_DONE
    } ctrl_state_t;

endpackage

/* hdl/sram_bank.sv */
module sram_bank #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              i_en,
    input  logic              i_we,
    input  sa_pkg::addr_t     i_addr,
    input  logic [WIDTH-1:0]  i_wr_data,
    output logic [WIDTH-1:0]  o_rd_data
);

    logic [WIDTH-1:0] mem [sa_pkg::BANK_DEPTH];

    // single port, write or registered read per cycle
    always_ff @(posedge clk)
    begin
        if (i_en)
        begin
            if (i_we)
            begin
                mem[i_addr] <= i_wr_data;
            end
            else
            begin
                o_rd_data <= mem[i_addr];    // holds while bank idle
            end
        end
    end

endmodule

/* hdl/operand_feeder.sv */
module operand_feeder #(
    parameter int LANES = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_busy,
    input  logic                          i_host_en,
    input  sa_pkg::addr_t                 i_host_addr,
    input  sa_pkg::operand_t [LANES-1:0]  i_host_data,
    input  sa_pkg::stream_cmd_t           i_cmd,
    output sa_pkg::operand_t [LANES-1:0]  o_data,
    output logic [LANES-1:0]              o_valid
);

    sa_pkg::stream_cmd_t lane_cmd [LANES];    // lane i command, i stages late

    assign lane_cmd[0] = i_cmd;

    genvar g;
    generate
        for (g = 0; g < LANES; g++)
        begin : g_lane
            logic          bank_en;
            logic          bank_we;
            sa_pkg::addr_t bank_addr;

            if (g > 0)
            begin : g_skew
                always_ff @(posedge clk or negedge rst_n)
                begin
                    if (!rst_n)
                        lane_cmd[g] <= '0;
                    else
                        lane_cmd[g] <= lane_cmd[g-1];
                end
            end

            // host owns the banks between jobs
            assign bank_en   = i_busy ? lane_cmd[g].rd_en : i_host_en;
            assign bank_we   = !i_busy && i_host_en;
            assign bank_addr = i_busy ? lane_cmd[g].addr : i_host_addr;

            sram_bank #(
                .WIDTH     (sa_pkg::DATA_W)
            ) bank_i (
                .clk       (clk),
                .i_en      (bank_en),
                .i_we      (bank_we),
                .i_addr    (bank_addr),
                .i_wr_data (i_host_data[g]),
                .o_rd_data (o_data[g])
            );

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    o_valid[g] <= 1'b0;
                else
                    o_valid[g] <= lane_cmd[g].valid;    // lines up with read data
            end
        end
    endgenerate

    // host writes must not collide with streaming reads
    a_no_host_wr_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_busy |-> !i_host_en
    );

endmodule

/* hdl/mac_pe.sv */
module mac_pe (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_clear,
    input  sa_pkg::operand_t i_left,
    input  logic             i_left_valid,
    input  sa_pkg::operand_t i_top,
    input  logic             i_top_valid,
    output sa_pkg::operand_t o_right,
    output logic             o_right_valid,
    output sa_pkg::operand_t o_down,
    output logic             o_down_valid,
    output sa_pkg::acc_t     o_acc
);

    logic [2*sa_pkg::DATA_W-1:0] prod;

    assign prod = i_left * i_top;

    // operand forwarding, payload only
    always_ff @(posedge clk)
    begin
        o_right <= i_left;
        o_down  <= i_top;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_right_valid <= 1'b0;
            o_down_valid  <= 1'b0;
            o_acc         <= '0;
        end
        else
        begin
            o_right_valid <= i_left_valid;
            o_down_valid  <= i_top_valid;
            if (i_clear)
                o_acc <= '0;
            else if (i_left_valid && i_top_valid)
                o_acc <= o_acc + sa_pkg::acc_t'(prod);    // wraps mod 2^32
        end
    end

endmodule

/* hdl/pe_array.sv */
module pe_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_clear,
    input  sa_pkg::row_vec_t              i_left,
    input  logic [sa_pkg::NUM_ROW-1:0]    i_left_valid,
    input  sa_pkg::col_vec_t              i_top,
    input  logic [sa_pkg::NUM_COL-1:0]    i_top_valid,
    input  sa_pkg::wb_cmd_t               i_wb,
    output sa_pkg::result_row_t           o_row
);

    localparam int NR = sa_pkg::NUM_ROW;
    localparam int NC = sa_pkg::NUM_COL;

    // horizontal and vertical operand buses, one extra slot at the far edge
    sa_pkg::operand_t h_data [NR][NC+1];
    logic             h_vld  [NR][NC+1];
    sa_pkg::operand_t v_data [NR+1][NC];
    logic             v_vld  [NR+1][NC];
    sa_pkg::acc_t     acc    [NR][NC];

    genvar r, c;
    generate
        for (r = 0; r < NR; r++)
        begin : g_left_in
            assign h_data[r][0] = i_left[r];
            assign h_vld[r][0]  = i_left_valid[r];
        end

        for (c = 0; c < NC; c++)
        begin : g_top_in
            assign v_data[0][c] = i_top[c];
            assign v_vld[0][c]  = i_top_valid[c];
        end

        for (r = 0; r < NR; r++)
        begin : g_row
            for (c = 0; c < NC; c++)
            begin : g_col
                mac_pe pe_i (
                    .clk           (clk),
                    .rst_n         (rst_n),
                    .i_clear       (i_clear),
                    .i_left        (h_data[r][c]),
                    .i_left_valid  (h_vld[r][c]),
                    .i_top         (v_data[r][c]),
                    .i_top_valid   (v_vld[r][c]),
                    .o_right       (h_data[r][c+1]),
                    .o_right_valid (h_vld[r][c+1]),
                    .o_down        (v_data[r+1][c]),
                    .o_down_valid  (v_vld[r+1][c]),
                    .o_acc         (acc[r][c])
                );
            end
        end
    endgenerate

    // ----------------------------------------
    // readout row select
    // ----------------------------------------
    always_comb
    begin
        for (int k = 0; k < NC; k++)
        begin
            o_row[k] = acc[i_wb.row][k];
        end
    end

endmodule

/* hdl/sa_controller.sv */
module sa_controller (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_start,
    input  sa_pkg::addr_t        i_rd_start_addr,
    input  sa_pkg::addr_t        i_rd_end_addr,
    output sa_pkg::stream_cmd_t  o_cmd,
    output logic                 o_clear,
    output sa_pkg::wb_cmd_t      o_wb,
    output logic                 o_busy,
    output logic                 o_done
);

    sa_pkg::ctrl_state_t         state;
    sa_pkg::addr_t               addr_cnt;     // current read address
    sa_pkg::addr_t               end_addr;     // latched at start
    logic [sa_pkg::DRAIN_W-1:0]  drain_cnt;
    sa_pkg::row_idx_t            row_cnt;

    // ----------------------------------------
    // state and counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= sa_pkg::ST_IDLE;
            addr_cnt  <= '0;
            end_addr  <= '0;
            drain_cnt <= '0;
            row_cnt   <= '0;
        end
        else
        begin
            case (state)
                sa_pkg::ST_IDLE:
                begin
                    if (i_start)
                    begin
                        addr_cnt <= i_rd_start_addr;
                        end_addr <= i_rd_end_addr;
                        state    <= sa_pkg::ST_CLEAR;
                    end
                end
                sa_pkg::ST_CLEAR:
                begin
                    state <= sa_pkg::ST_STREAM;    // accumulators zeroed here
                end
                sa_pkg::ST_STREAM:
                begin
                    if (addr_cnt == end_addr)
                    begin
                        drain_cnt <= '0;
                        state     <= sa_pkg::ST_DRAIN;
                    end
                    else
                    begin
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                sa_pkg::ST_DRAIN:
                begin
                    if (drain_cnt == sa_pkg::DRAIN_W'(sa_pkg::DRAIN_CYCLES - 1))
                    begin
                        row_cnt <= '0;
                        state   <= sa_pkg::ST_WRITEBACK;
                    end
                    else
                    begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                sa_pkg::ST_WRITEBACK:
                begin
                    if (row_cnt == sa_pkg::row_idx_t'(sa_pkg::NUM_ROW - 1))
                        state <= sa_pkg::ST_DONE;
                    else
                        row_cnt <= row_cnt + 1'b1;    // one result row per cycle
                end
                sa_pkg::ST_DONE:
                begin
                    state <= sa_pkg::ST_IDLE;
                end
                default:
                begin
                    state <= sa_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign o_cmd.rd_en = (state == sa_pkg::ST_STREAM);
    assign o_cmd.valid = (state == sa_pkg::ST_STREAM);
    assign o_cmd.addr  = addr_cnt;
    assign o_clear     = (state == sa_pkg::ST_CLEAR);
    assign o_wb.en     = (state == sa_pkg::ST_WRITEBACK);
    assign o_wb.row    = row_cnt;
    assign o_busy      = (state != sa_pkg::ST_IDLE) && (state != sa_pkg::ST_DONE);
    assign o_done      = (state == sa_pkg::ST_DONE);

    // a new job only from idle
    a_start_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_start |-> state == sa_pkg::ST_IDLE
    );

    a_range_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_start |-> i_rd_start_addr <= i_rd_end_addr
    );

endmodule

/* hdl/result_store.sv */
module result_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sa_pkg::wb_cmd_t      i_wb,
    input  sa_pkg::result_row_t  i_row,
    input  logic                 i_busy,
    input  logic                 i_rd_en,
    input  sa_pkg::addr_t        i_rd_addr,
    output sa_pkg::result_row_t  o_rd_data
);

    logic          bank_en;
    sa_pkg::addr_t bank_addr;

    // writeback has the port during a job, host reads otherwise
    assign bank_en   = i_wb.en || i_rd_en;
    assign bank_addr = i_wb.en ? sa_pkg::addr_t'(i_wb.row) : i_rd_addr;

    genvar c;
    generate
        for (c = 0; c < sa_pkg::NUM_COL; c++)
        begin : g_col
            sram_bank #(
                .WIDTH     (sa_pkg::ACC_W)
            ) bank_i (
                .clk       (clk),
                .i_en      (bank_en),
                .i_we      (i_wb.en),
                .i_addr    (bank_addr),
                .i_wr_data (i_row[c]),
                .o_rd_data (o_rd_data[c])
            );
        end
    endgenerate

    // results are only stable after o_done
    a_no_host_rd_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_busy |-> !i_rd_en
    );

endmodule

/* hdl/systolic_array_top.sv */
module systolic_array_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sa_pkg::host_left_wr_t i_left_wr,
    input  sa_pkg::host_top_wr_t  i_top_wr,
    input  logic                  i_start,
    input  sa_pkg::addr_t         i_rd_start_addr,
    input  sa_pkg::addr_t         i_rd_end_addr,
    input  logic                  i_down_rd_en,
    input  sa_pkg::addr_t         i_down_rd_addr,
    output sa_pkg::result_row_t   o_down_rd_data,
    output logic                  o_busy,
    output logic                  o_done
);

    sa_pkg::stream_cmd_t            stream_cmd;
    logic                           clear_acc;
    sa_pkg::wb_cmd_t                wb_cmd;
    sa_pkg::row_vec_t               left_data;
    logic [sa_pkg::NUM_ROW-1:0]     left_valid;
    sa_pkg::col_vec_t               top_data;
    logic [sa_pkg::NUM_COL-1:0]     top_valid;
    sa_pkg::result_row_t            wb_row;

    // ----------------------------------------
    // sequencing
    // ----------------------------------------
    sa_controller sa_controller_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_rd_start_addr (i_rd_start_addr),
        .i_rd_end_addr   (i_rd_end_addr),
        .o_cmd           (stream_cmd),
        .o_clear         (clear_acc),
        .o_wb            (wb_cmd),
        .o_busy          (o_busy),
        .o_done          (o_done)
    );

    // ----------------------------------------
    // operand edges
    // ----------------------------------------
    operand_feeder #(
        .LANES       (sa_pkg::NUM_ROW)
    ) left_feeder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_busy      (o_busy),
        .i_host_en   (i_left_wr.en),
        .i_host_addr (i_left_wr.addr),
        .i_host_data (i_left_wr.data),
        .i_cmd       (stream_cmd),
        .o_data      (left_data),
        .o_valid     (left_valid)
    );

    operand_feeder #(
        .LANES       (sa_pkg::NUM_COL)
    ) top_feeder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_busy      (o_busy),
        .i_host_en   (i_top_wr.en),
        .i_host_addr (i_top_wr.addr),
        .i_host_data (i_top_wr.data),
        .i_cmd       (stream_cmd),      // same range as left edge
        .o_data      (top_data),
        .o_valid     (top_valid)
    );

    // ----------------------------------------
    // datapath and results
    // ----------------------------------------
    pe_array pe_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_clear      (clear_acc),
        .i_left       (left_data),
        .i_left_valid (left_valid),
        .i_top        (top_data),
        .i_top_valid  (top_valid),
        .i_wb         (wb_cmd),
        .o_row        (wb_row)
    );

    result_store result_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wb      (wb_cmd),
        .i_row     (wb_row),
        .i_busy    (o_busy),
        .i_rd_en   (i_down_rd_en),
        .i_rd_addr (i_down_rd_addr),
        .o_rd_data (o_down_rd_data)
    );

endmodule

/* tests/sa_ref_model.svh */
`ifndef SA_REF_MODEL_SVH
`define SA_REF_MODEL_SVH

// ----------------------------------------
// operand mirror of both edges
// ----------------------------------------
sa_pkg::row_vec_t model_left [sa_pkg::BANK_DEPTH];    // A columns, lane r = A[r][k]
sa_pkg::col_vec_t model_top  [sa_pkg::BANK_DEPTH];    // B rows, lane c = B[k][c]

function automatic void model_write(
    input sa_pkg::addr_t    addr,
    input sa_pkg::row_vec_t lv,
    input sa_pkg::col_vec_t tv
);
    model_left[addr] = lv;
    model_top[addr]  = tv;
endfunction

// C[r][c] = sum over k of A[r][k] * B[k][c], modulo 2^32
function automatic sa_pkg::result_row_t model_row(
    input int r,
    input int first,
    input int last
);
    sa_pkg::result_row_t row;
    sa_pkg::acc_t        term;
    row = '0;
    for (int c = 0; c < sa_pkg::NUM_COL; c++)
    begin
        for (int k = first; k <= last; k++)
        begin
            term   = sa_pkg::acc_t'(model_left[k][r]) * sa_pkg::acc_t'(model_top[k][c]);
            row[c] = row[c] + term;    // wraps like the hardware
        end
    end
    return row;
endfunction

`endif

/* tests/tb_systolic_array.sv */
module tb_systolic_array;

    localparam int JOB_OVERHEAD   = 19;    // start to done beyond the stream length
    localparam int TIMEOUT_CYCLES = 8 * (sa_pkg::BANK_DEPTH + JOB_OVERHEAD + 80) + 200;
    localparam int ALL_ONES_SUM   = 64 * 255 * 255;

    logic                  clk;
    logic                  rst_n;
    sa_pkg::host_left_wr_t i_left_wr;
    sa_pkg::host_top_wr_t  i_top_wr;
    logic                  i_start;
    sa_pkg::addr_t         i_rd_start_addr;
    sa_pkg::addr_t         i_rd_end_addr;
    logic                  i_down_rd_en;
    sa_pkg::addr_t         i_down_rd_addr;
    sa_pkg::result_row_t   o_down_rd_data;
    logic                  o_busy;
    logic                  o_done;

    integer seed;
    int     cycles;
    int     checks;
    int     value_errors;
    int     timing_errors;

    `include "sa_ref_model.svh"

    systolic_array_top systolic_array_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_left_wr       (i_left_wr),
        .i_top_wr        (i_top_wr),
        .i_start         (i_start),
        .i_rd_start_addr (i_rd_start_addr),
        .i_rd_end_addr   (i_rd_end_addr),
        .i_down_rd_en    (i_down_rd_en),
        .i_down_rd_addr  (i_down_rd_addr),
        .o_down_rd_data  (o_down_rd_data),
        .o_busy          (o_busy),
        .o_done          (o_done)
    );

    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic void clear_host_inputs();
        i_left_wr.en = 1'b0;
        i_top_wr.en  = 1'b0;
        i_down_rd_en = 1'b0;
        i_start      = 1'b0;
    endfunction

    task automatic write_operands(
        input int               addr,
        input sa_pkg::row_vec_t lv,
        input sa_pkg::col_vec_t tv
    );
        @(negedge clk);
        clear_host_inputs();
        i_left_wr.en   = 1'b1;
        i_left_wr.addr = sa_pkg::addr_t'(addr);
        i_left_wr.data = lv;
        i_top_wr.en    = 1'b1;
        i_top_wr.addr  = sa_pkg::addr_t'(addr);
        i_top_wr.data  = tv;
        model_write(sa_pkg::addr_t'(addr), lv, tv);
    endtask

    task automatic write_random(input int addr);
        sa_pkg::row_vec_t lv;
        sa_pkg::col_vec_t tv;
        for (int i = 0; i < sa_pkg::NUM_ROW; i++)
            lv[i] = sa_pkg::operand_t'($random(seed));
        for (int i = 0; i < sa_pkg::NUM_COL; i++)
            tv[i] = sa_pkg::operand_t'($random(seed));
        write_operands(addr, lv, tv);
    endtask

    // data is sampled one cycle after the enable
    task automatic read_row(input int addr, output sa_pkg::result_row_t row);
        @(negedge clk);
        clear_host_inputs();
        i_down_rd_en   = 1'b1;
        i_down_rd_addr = sa_pkg::addr_t'(addr);
        @(negedge clk);
        clear_host_inputs();
        row = o_down_rd_data;
    endtask

    task automatic check_idle_flags();
        checks++;
        assert (!o_busy && !o_done) else
        begin
            timing_errors++;
            $display("busy or done went high at %0t while no job was running", $time);
        end
    endtask

    task automatic check_results(input int first, input int last);
        sa_pkg::result_row_t exp;
        sa_pkg::result_row_t got;
        sa_pkg::result_row_t again;
        for (int r = 0; r < sa_pkg::NUM_ROW; r++)
        begin
            exp = model_row(r, first, last);
            read_row(r, got);
            read_row(r, again);
            for (int c = 0; c < sa_pkg::NUM_COL; c++)
            begin
                checks++;
                assert (got[c] == exp[c]) else
                begin
                    value_errors++;
                    $display("ERROR: time %0t range %0d..%0d C[%0d][%0d] got %h expected %h",
                             $time, first, last, r, c, got[c], exp[c]);
                end
            end
            checks++;
            assert (again == got) else
            begin
                value_errors++;
                $display("ERROR: time %0t row %0d changed on repeated read", $time, r);
            end
        end
    endtask

    // ----------------------------------------
    // one job with its timing checks
    // ----------------------------------------
    task automatic run_job(input int first, input int last);
        int len;
        int waited;
        len = last - first + 1;
        @(negedge clk);
        clear_host_inputs();
        i_start         = 1'b1;
        i_rd_start_addr = sa_pkg::addr_t'(first);
        i_rd_end_addr   = sa_pkg::addr_t'(last);
        @(negedge clk);
        i_start = 1'b0;
        waited  = 1;
        checks++;
        assert (o_busy) else
        begin
            timing_errors++;
            $display("busy did not rise one cycle after start at %0t", $time);
        end
        while (!o_done && waited < len + JOB_OVERHEAD + 20)
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (o_done && waited == len + JOB_OVERHEAD && !o_busy) else
        begin
            timing_errors++;
            $display("done for range %0d..%0d seen after %0d cycles, %0d expected",
                     first, last, waited, len + JOB_OVERHEAD);
        end
        @(negedge clk);
        checks++;
        assert (!o_done) else
        begin
            timing_errors++;
            $display("done stayed high for more than one cycle at %0t", $time);
        end
        check_results(first, last);
    endtask

    initial
    begin
        int                  first;
        int                  len;
        int                  base;
        sa_pkg::result_row_t row;

        seed            = 47245;
        cycles          = 0;
        checks          = 0;
        value_errors    = 0;
        timing_errors   = 0;
        clk             = 1'b0;
        rst_n           = 1'b0;
        i_left_wr       = '0;
        i_top_wr        = '0;
        i_start         = 1'b0;
        i_rd_start_addr = '0;
        i_rd_end_addr   = '0;
        i_down_rd_en    = 1'b0;
        i_down_rd_addr  = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // idle traffic fills every operand address
        check_idle_flags();
        for (int a = 0; a < sa_pkg::BANK_DEPTH; a++)
        begin
            write_random(a);
            check_idle_flags();
        end
        repeat (3)
        begin
            read_row(rand_below(sa_pkg::NUM_ROW), row);
            check_idle_flags();
        end

        first = rand_below(48);    // single job over 1 to 16 addresses
        len   = 1 + rand_below(16);
        run_job(first, first + len - 1);

        base = rand_below(40);     // back to back jobs on overlapping ranges
        run_job(base, base + 7);
        run_job(base + 3, base + 12);
        run_job(base + 1, base + 4);

        // ----------------------------------------
        // largest sums then overwrite
        // ----------------------------------------
        for (int a = 0; a < sa_pkg::BANK_DEPTH; a++)
            write_operands(a, '1, '1);
        run_job(0, sa_pkg::BANK_DEPTH - 1);
        read_row(0, row);
        for (int c = 0; c < sa_pkg::NUM_COL; c++)
        begin
            checks++;
            assert (row[c] == sa_pkg::acc_t'(ALL_ONES_SUM)) else
            begin
                value_errors++;
                $display("ERROR: time %0t all ones sum col %0d got %0d", $time, c, row[c]);
            end
        end
        for (int a = 0; a < 8; a++)
            write_random(a);
        for (int a = 2; a <= 4; a++)
            write_random(a);       // latest data must win
        run_job(0, 7);

        repeat (2)
        begin
            repeat (1 + rand_below(8)) write_random(rand_below(sa_pkg::BANK_DEPTH));
            first = rand_below(32);
            len   = 1 + rand_below(32);
            run_job(first, first + len - 1);
        end

        $display("checks: %0d, value errors: %0d, timing errors: %0d",
                 checks, value_errors, timing_errors);
        if (value_errors + timing_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* systolic_array.f */
+incdir+tests
hdl/sa_pkg.sv
hdl/sram_bank.sv
hdl/operand_feeder.sv
hdl/mac_pe.sv
hdl/pe_array.sv
hdl/sa_controller.sv
hdl/result_store.sv
hdl/systolic_array_top.sv
tests/tb_systolic_array.sv

/* Makefile */
# Verilator build and run of the systolic array testbench

SOURCES := $(shell grep '\.sv$$' systolic_array.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_systolic_array: systolic_array.f $(SOURCES) tests/sa_ref_model.svh
	verilator --binary --assert --top-module tb_systolic_array -f systolic_array.f

run: obj_dir/Vtb_systolic_array
	./obj_dir/Vtb_systolic_array | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
